// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dq_group_phy
FLIST     ?= dq_group_phy.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_dq_group_phy.sv ====
`timescale 1ns/1ps

module tb_dq_group_phy;
    import ddr_phy_pkg::*;

    logic                 pll_mem_clk;
    logic                 rst_n;
    logic                 wr_valid;
    logic                 wr_ready;
    logic [HR_WIDTH-1:0]  wr_data;
    logic [OE_WIDTH-1:0]  wr_oe;
    logic [1:0]           wr_strobe_ena;
    logic [PIN_WIDTH-1:0] dq_out_lo;
    logic [PIN_WIDTH-1:0] dq_out_hi;
    logic [PIN_WIDTH-1:0] dq_oe;
    logic                 dqs_oe;
    logic [PIN_WIDTH-1:0] rd_pair_lo;
    logic [PIN_WIDTH-1:0] rd_pair_hi;
    logic                 rd_valid;
    logic [HR_WIDTH-1:0]  rdata;
    logic                 rdata_valid;

    integer seed = 79;
    integer errors = 0;
    integer cyc = 0;                   // Edges seen with reset released
    string  test_name = "reset_idle";

    // Expected pad and read results, indexed by edge count modulo 8
    logic [PIN_WIDTH-1:0] e_lo  [8];
    logic [PIN_WIDTH-1:0] e_hi  [8];
    logic [PIN_WIDTH-1:0] e_oe  [8];
    logic                 e_dqs [8];
    logic                 e_rv  [8];
    logic [HR_WIDTH-1:0]  e_rd  [8];

    logic                     taken = 1'b0;     // Offer accepted at the coming edge
    logic                     acc_prev = 1'b0;
    logic                     have_first = 1'b0;
    logic [RD_PAIR_WIDTH-1:0] first_pair;

    dq_group_phy i_dut (.*);

    always #10 pll_mem_clk = ~pll_mem_clk;

    always @(posedge pll_mem_clk)
    begin
        if (rst_n)
            cyc <= cyc + 1;
    end

    task automatic check_equal(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic logic ring_empty();
        logic busy;
        busy = 1'b0;
        for (int i = 0; i < 8; i++)
            busy = busy | (|e_oe[i]) | e_dqs[i] | e_rv[i];
        return !busy;
    endfunction

    // ##############################
    // Reference model and checks
    // ##############################
    always @(negedge pll_mem_clk)
    begin
        int                       slot;
        int                       e;
        logic                     exp_ready;
        logic [RD_PAIR_WIDTH-1:0] pair;
        if (!rst_n)
        begin
            check_equal("dq_oe in reset", 0, 32'(dq_oe));
            check_equal("dqs_oe in reset", 0, 32'(dqs_oe));
            check_equal("rdata_valid in reset", 0, 32'(rdata_valid));
            for (int i = 0; i < 8; i++)
            begin
                e_lo[i]  = '0;
                e_hi[i]  = '0;
                e_oe[i]  = '0;
                e_dqs[i] = 1'b0;
                e_rv[i]  = 1'b0;
                e_rd[i]  = '0;
            end
        end
        else
        begin
            slot = cyc % 8;
            if (cyc >= 1)                                  // Pad data registered once
            begin
                check_equal("dq_out_lo", 32'(e_lo[slot]), 32'(dq_out_lo));
                check_equal("dq_out_hi", 32'(e_hi[slot]), 32'(dq_out_hi));
            end
            check_equal("dq_oe", 32'(e_oe[slot]), 32'(dq_oe));
            check_equal("dqs_oe", 32'(e_dqs[slot]), 32'(dqs_oe));
            check_equal("rdata_valid", 32'(e_rv[slot]), 32'(rdata_valid));
            if (e_rv[slot])
                check_equal("rdata", e_rd[slot], rdata);
            e_lo[slot]  = '0;
            e_hi[slot]  = '0;
            e_oe[slot]  = '0;
            e_dqs[slot] = 1'b0;
            e_rv[slot]  = 1'b0;

            // Inputs now stable for the next edge
            e = cyc + 1;
            exp_ready = (cyc >= 1) && !acc_prev;           // Busy only in first cycle of a word
            check_equal("wr_ready", 32'(exp_ready), 32'(wr_ready));
            taken = wr_valid && exp_ready;
            if (taken)
            begin
                e_lo[(e + 1) % 8]  = wr_data[7:0];
                e_hi[(e + 1) % 8]  = wr_data[15:8];
                e_oe[(e + 1) % 8]  = wr_oe[7:0];
                e_lo[(e + 2) % 8]  = wr_data[23:16];
                e_hi[(e + 2) % 8]  = wr_data[31:24];
                e_oe[(e + 2) % 8]  = wr_oe[15:8];
                e_dqs[(e + 2) % 8] = wr_strobe_ena[0];
                e_dqs[(e + 3) % 8] = wr_strobe_ena[1];
            end
            acc_prev = taken;

            if (rd_valid)
            begin
                pair = {rd_pair_hi, rd_pair_lo};
                if (have_first)
                begin
                    e_rv[(e + 1) % 8] = 1'b1;              // Lane capture, then packer
                    e_rd[(e + 1) % 8] = {pair, first_pair};
                end
                else
                    first_pair = pair;
                have_first = !have_first;
            end
        end
    end

    // ##############################
    // Stimulus
    // ##############################
    task automatic step(input bit offer, input bit reads);
        @(posedge pll_mem_clk);
        #2;
        if (!wr_valid || taken)                            // Hold an offer until taken
        begin
            wr_valid = offer;
            if (offer)
            begin
                wr_data       = $random(seed);
                wr_oe         = OE_WIDTH'($random(seed));
                wr_strobe_ena = 2'($random(seed));
            end
        end
        rd_valid   = reads && ($random(seed) % 2 != 0);
        rd_pair_lo = PIN_WIDTH'($random(seed));
        rd_pair_hi = PIN_WIDTH'($random(seed));
    endtask

    task automatic report_timeout(input string why);
        errors++;
        $display("Timeout: %s", why);
    endtask

    initial
    begin
        int t;
        pll_mem_clk   = 1'b0;
        rst_n         = 1'b0;
        wr_valid      = 1'b0;
        wr_data       = '0;
        wr_oe         = '0;
        wr_strobe_ena = '0;
        rd_pair_lo    = '0;
        rd_pair_hi    = '0;
        rd_valid      = 1'b0;
        repeat (4) @(posedge pll_mem_clk);
        #2 rst_n = 1'b1;

        repeat (5) step(0, 0);

        test_name = "single_word";
        step(1, 0);
        @(negedge pll_mem_clk);
        #1;
        t = 0;
        while (!taken)
        begin
            if (t++ > 20)
            begin
                report_timeout("single word was never accepted");
                break;
            end
            step(0, 0);
            @(negedge pll_mem_clk);
            #1;
        end
        repeat (5) step(0, 0);

        test_name = "stream";
        repeat (16) step(1, 0);
        repeat (5) step(0, 0);

        test_name = "random_mix";
        repeat (300) step($random(seed) % 3 != 0, 1);

        test_name = "drain";
        t = 0;
        step(0, 0);
        while (!ring_empty() || wr_valid)
        begin
            if (t++ > 20)
            begin
                report_timeout("outputs did not return to idle");
                break;
            end
            step(0, 0);
        end
        repeat (3) step(0, 0);

        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== design/ddr_phy_pkg.sv ====
package ddr_phy_pkg;

    // ############################
    // Group geometry
    // ############################
    localparam int PIN_WIDTH     = 8;                      // DQ pins per byte group
    localparam int HR_BEATS      = 4;                      // Beats per half-rate word
    localparam int FR_BEATS      = 2;                      // Beats per full-rate cycle

    localparam int HR_WIDTH      = PIN_WIDTH * HR_BEATS;   // Half-rate data word
    localparam int RD_PAIR_WIDTH = PIN_WIDTH * FR_BEATS;   // One captured lo/hi pair
    localparam int OE_WIDTH      = PIN_WIDTH * FR_BEATS;   // One enable bit per pin per cycle

    // Write word as the user delivers it, or split into beat slices
    // t0 sits in the lowest PIN_WIDTH bits, t3 in the highest
    typedef union packed {
        logic [HR_WIDTH-1:0] flat;
        struct packed {
            logic [PIN_WIDTH-1:0] t3;
            logic [PIN_WIDTH-1:0] t2;
            logic [PIN_WIDTH-1:0] t1;
            logic [PIN_WIDTH-1:0] t0;
        } beats;
    } hr_word_u;

endpackage

// ==== design/dq_group_phy.sv ====
`timescale 1ns/1ps

module dq_group_phy
    import ddr_phy_pkg::*;
(
    input  logic                 pll_mem_clk,
    input  logic                 rst_n,

    // User write side
    input  logic                 wr_valid,
    output logic                 wr_ready,
    input  logic [HR_WIDTH-1:0]  wr_data,
    input  logic [OE_WIDTH-1:0]  wr_oe,
    input  logic [1:0]           wr_strobe_ena,

    // Pad side
    output logic [PIN_WIDTH-1:0] dq_out_lo,
    output logic [PIN_WIDTH-1:0] dq_out_hi,
    output logic [PIN_WIDTH-1:0] dq_oe,
    output logic                 dqs_oe,

    // Read side
    input  logic [PIN_WIDTH-1:0] rd_pair_lo,
    input  logic [PIN_WIDTH-1:0] rd_pair_hi,
    input  logic                 rd_valid,
    output logic [HR_WIDTH-1:0]  rdata,
    output logic                 rdata_valid
);

    dq_lane_if bus ();

    // ############################
    // Write staging and DQS enable
    // ############################
    dq_write_stager i_stager (
        .pll_mem_clk   (pll_mem_clk),
        .rst_n         (rst_n),
        .wr_valid      (wr_valid),
        .wr_ready      (wr_ready),
        .wr_data       (wr_data),
        .wr_oe         (wr_oe),
        .wr_strobe_ena (wr_strobe_ena),
        .dqs_oe        (dqs_oe),
        .bus           (bus.stager)
    );

    // ############################
    // One lane per DQ pin
    // ############################
    for (genvar i = 0; i < PIN_WIDTH; i++)
    begin : gen_lane
        dq_lane #(
            .LANE (i)
        ) i_lane (
            .pll_mem_clk (pll_mem_clk),
            .rst_n       (rst_n),
            .bus         (bus.lane),
            .rd_pair_lo  (rd_pair_lo[i]),
            .rd_pair_hi  (rd_pair_hi[i]),
            .dq_out_lo   (dq_out_lo[i]),
            .dq_out_hi   (dq_out_hi[i]),
            .dq_oe       (dq_oe[i])
        );
    end

    // Full-rate to half-rate read packing
    rd_hr_packer i_packer (
        .pll_mem_clk (pll_mem_clk),
        .rst_n       (rst_n),
        .rd_valid    (rd_valid),
        .bus         (bus.packer),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

// ==== design/dq_lane.sv ====
`timescale 1ns/1ps

module dq_lane
    import ddr_phy_pkg::*;
#(
    parameter int LANE = 0                   // Pin index within the group
)
(
    input  logic      pll_mem_clk,
    input  logic      rst_n,
    dq_lane_if.lane   bus,
    input  logic      rd_pair_lo,
    input  logic      rd_pair_hi,
    output logic      dq_out_lo,
    output logic      dq_out_hi,
    output logic      dq_oe
);

    logic sel_lo;
    logic sel_hi;
    logic sel_oe;
    logic rd_lo_q;
    logic rd_hi_q;

    // t0/t1 in the first cycle, t2/t3 in the second
    assign sel_lo = bus.wr_first ? bus.wr_word.beats.t0[LANE] : bus.wr_word.beats.t2[LANE];
    assign sel_hi = bus.wr_first ? bus.wr_word.beats.t1[LANE] : bus.wr_word.beats.t3[LANE];
    assign sel_oe = bus.wr_first ? bus.wr_oe_word[LANE] : bus.wr_oe_word[LANE + PIN_WIDTH];

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
            dq_oe <= 1'b0;
        else
            dq_oe <= bus.wr_active && sel_oe;
    end

    // Pad data, held at zero while the stager is idle
    always_ff @(posedge pll_mem_clk)
    begin
        dq_out_lo <= bus.wr_active && sel_lo;
        dq_out_hi <= bus.wr_active && sel_hi;
    end

    // Read capture
    always_ff @(posedge pll_mem_clk)
    begin
        rd_lo_q <= rd_pair_lo;
        rd_hi_q <= rd_pair_hi;
    end

    assign bus.rd_lo[LANE] = rd_lo_q;
    assign bus.rd_hi[LANE] = rd_hi_q;

endmodule

// ==== design/dq_lane_if.sv ====
`timescale 1ns/1ps

interface dq_lane_if
    import ddr_phy_pkg::*;
();

    // Write side, held by the stager for two full-rate cycles
    hr_word_u               wr_word;     // Current half-rate word
    logic [OE_WIDTH-1:0]    wr_oe_word;  // Per-pin enables, low byte is first cycle
    logic                   wr_active;   // A held word is being sent
    logic                   wr_first;    // First of the two full-rate cycles

    // Read side, one bit per lane
    logic [PIN_WIDTH-1:0]   rd_lo;
    logic [PIN_WIDTH-1:0]   rd_hi;

    modport stager (
        output wr_word,
        output wr_oe_word,
        output wr_active,
        output wr_first
    );

    modport lane (
        input  wr_word,
        input  wr_oe_word,
        input  wr_active,
        input  wr_first,
        output rd_lo,
        output rd_hi
    );

    modport packer (
        input  rd_lo,
        input  rd_hi
    );

endinterface

// ==== design/dq_write_stager.sv ====
`timescale 1ns/1ps

module dq_write_stager
    import ddr_phy_pkg::*;
(
    input  logic                pll_mem_clk,
    input  logic                rst_n,
    input  logic                wr_valid,
    output logic                wr_ready,
    input  logic [HR_WIDTH-1:0] wr_data,
    input  logic [OE_WIDTH-1:0] wr_oe,
    input  logic [1:0]          wr_strobe_ena,
    output logic                dqs_oe,
    dq_lane_if.stager           bus
);

    logic       run;         // Set at the first edge out of reset
    logic       accept;
    logic [1:0] strobe_q;    // Strobe enable held with the word
    logic       strobe_sel;
    logic       strobe_fr;   // Serialized strobe enable, same cycle as DQ pads

    // Free when idle, or in the last cycle of the held word
    assign wr_ready = run && (!bus.wr_active || !bus.wr_first);
    assign accept   = wr_valid && wr_ready;

    // ############################
    // Beat-pair select and hold state
    // ############################
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            run           <= 1'b0;
            bus.wr_active <= 1'b0;
            bus.wr_first  <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
            if (accept)
            begin
                bus.wr_active <= 1'b1;
                bus.wr_first  <= 1'b1;          // Restart select on every new word
            end
            else
            begin
                bus.wr_first <= ~bus.wr_first;
                if (!bus.wr_first)
                    bus.wr_active <= 1'b0;      // Second cycle done, nothing queued
            end
        end
    end

    // Word payload
    always_ff @(posedge pll_mem_clk)
    begin
        if (accept)
        begin
            bus.wr_word.flat <= wr_data;
            bus.wr_oe_word   <= wr_oe;
            strobe_q         <= wr_strobe_ena;
        end
    end

    // ############################
    // DQS output enable
    // ############################
    assign strobe_sel = bus.wr_first ? strobe_q[0] : strobe_q[1];

    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            strobe_fr <= 1'b0;
            dqs_oe    <= 1'b0;
        end
        else
        begin
            strobe_fr <= bus.wr_active && strobe_sel;
            dqs_oe    <= strobe_fr;                // One cycle behind the DQ beats
        end
    end

endmodule

// ==== design/rd_hr_packer.sv ====
`timescale 1ns/1ps

module rd_hr_packer
    import ddr_phy_pkg::*;
(
    input  logic                pll_mem_clk,
    input  logic                rst_n,
    input  logic                rd_valid,
    dq_lane_if.packer           bus,
    output logic [HR_WIDTH-1:0] rdata,
    output logic                rdata_valid
);

    logic                     rd_valid_d;   // Aligned with lane capture
    logic                     half;         // First pair stored, waiting for second
    logic [RD_PAIR_WIDTH-1:0] first_pair;
    logic [RD_PAIR_WIDTH-1:0] pair;

    assign pair = {bus.rd_hi, bus.rd_lo};   // lo below hi

    // ############################
    // Pairing control
    // ############################
    always_ff @(posedge pll_mem_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid_d  <= 1'b0;
            half        <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            rd_valid_d  <= rd_valid;
            rdata_valid <= rd_valid_d && half;
            if (rd_valid_d)
                half <= ~half;
        end
    end

    // Earlier pair goes to the lower half of the word
    always_ff @(posedge pll_mem_clk)
    begin
        if (rd_valid_d && !half)
            first_pair <= pair;
        if (rd_valid_d && half)
            rdata <= {pair, first_pair};
    end

endmodule

// ==== dq_group_phy.f ====
design/ddr_phy_pkg.sv
design/dq_lane_if.sv
design/dq_write_stager.sv
design/dq_lane.sv
design/rd_hr_packer.sv
design/dq_group_phy.sv
bench/tb_dq_group_phy.sv
